/* bench/tetris_asserts.sv */
`timescale 1ns/1ps

module tetris_asserts
	import board_pkg::*;
	import piece_pkg::*;
(
	input logic      Clk,
	input logic      Reset,
	input logic      Start,
	input logic      Ack,
	input logic      Left,
	input logic      q_I,
	input logic      q_Gen,
	input logic      q_Rot,
	input logic      q_Col,
	input logic      q_Lose,
	input board_t    blocks,
	input score_t    score,
	input cell_idx_t location,
	input orient_t   orientation
);

	int fail_cnt = 0;

	board_t      gen_stack;
	board_t      new_cells;
	board_t      spawn_sq;
	board_t      spawn_bar;
	board_t      cur_mask;
	board_t      stack_now;
	board_t      bar_mask;
	placement_t  bar_pl;
	piece_kind_t kind_reg;
	piece_kind_t cur_kind;
	logic        gen_d;
	logic        left_fits;
	logic        bar_shown;

	task automatic flag(input string msg);
		fail_cnt++;
		$error("** Error %0t: %s", $time, msg);
	endtask

	function automatic logic has_full_row(board_t b);
		for (int r = 0; r < BOARD_ROWS; r++)
			if (&b[r*BOARD_COLS +: BOARD_COLS])
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic logic step_ok(cell_idx_t prev, cell_idx_t cur);
		return cur == prev || cur == prev - 8'd1 || cur == prev + 8'd1 || cur == prev - 8'd8;
	endfunction

	////////////////////////////////////////////////////////////
	// Piece kind, seen as the cells added by the spawn
	////////////////////////////////////////////////////////////

	assign spawn_sq  = placement_mask(piece_place(SQUARE, ORIENT_FLAT, SPAWN_ANCHOR, 0, 0));
	assign spawn_bar = placement_mask(piece_place(BAR, ORIENT_FLAT, SPAWN_ANCHOR, 0, 0));
	assign new_cells = blocks & ~gen_stack;
	assign cur_kind  = gen_d ? ((new_cells == spawn_sq) ? SQUARE : BAR) : kind_reg;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			gen_stack <= '0;
			gen_d     <= 1'b0;
			kind_reg  <= SQUARE;
		end
		else
		begin
			gen_d <= q_Gen;
			if (q_Gen)
				gen_stack <= blocks;
			if (gen_d)
				kind_reg <= cur_kind;
		end
	end

	assign cur_mask  = placement_mask(piece_place(cur_kind, orientation, location, 0, 0));
	assign stack_now = blocks & ~cur_mask;
	assign left_fits = placement_fits(piece_place(cur_kind, orientation, location, 0, -1),
		stack_now);

	// Bar cells at the present anchor and orientation
	assign bar_pl    = piece_place(BAR, orientation, location, 0, 0);
	assign bar_mask  = placement_mask(bar_pl);
	assign bar_shown = !bar_pl.off_board && ((blocks & bar_mask) == bar_mask);

	////////////////////////////////////////////////////////////
	// Game rules
	////////////////////////////////////////////////////////////

	a_onehot: assert property (@(posedge Clk) disable iff (Reset)
		$onehot({q_Lose, q_Col, q_Rot, q_Gen, q_I}))
		else flag("state flags are not one-hot");
	a_init_clear: assert property (@(posedge Clk) disable iff (Reset)
		q_I |=> (score == '0 && blocks == '0))
		else flag("board or score not cleared in INITIAL");
	a_spawn: assert property (@(posedge Clk) disable iff (Reset)
		q_Gen |=> q_Lose || (q_Rot && location == SPAWN_ANCHOR && orientation == ORIENT_FLAT
		&& (new_cells == spawn_sq || new_cells == spawn_bar)))
		else flag("spawn placement or next state wrong");
	a_step: assert property (@(posedge Clk) disable iff (Reset)
		q_Rot |=> step_ok($past(location), location))
		else flag("location step is not 0, -1, +1 or -8");
	a_left: assert property (@(posedge Clk) disable iff (Reset)
		q_Rot && Left && left_fits |=> location == $past(location) - 8'd1)
		else flag("fitting Left move not applied");
	a_rotate: assert property (@(posedge Clk) disable iff (Reset)
		$past(q_Rot) && orientation != $past(orientation)
		|-> location == $past(location) && cur_kind == BAR && bar_shown)
		else flag("rotation moved the anchor or gave a wrong shape");
	a_score: assert property (@(posedge Clk) disable iff (Reset)
		score != $past(score) |-> score == $past(score) + 8'd1 || (score == '0 && $past(q_I)))
		else flag("score changed by other than +1");
	a_cleared: assert property (@(posedge Clk) disable iff (Reset)
		$fell(q_Col) && q_Gen |-> !has_full_row(blocks))
		else flag("full row left after COLLISION");
	a_ack: assert property (@(posedge Clk) disable iff (Reset)
		q_Lose && Ack |=> q_I)
		else flag("Ack in LOSE did not return to INITIAL");
	a_start: assert property (@(posedge Clk) disable iff (Reset)
		q_I && Start |=> q_Gen)
		else flag("Start in INITIAL did not reach GENERATE");

endmodule

bind tetris_top tetris_asserts asserts_i (.*);

/* bench/tetris_tb.sv */
`timescale 1ns/1ps

module tetris_tb
	import board_pkg::*;
	import piece_pkg::*;
();

	// About 150 pieces of roughly 130 cycles each
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int RANDOM_CYCLES  = 15000;
	localparam int RESET_CYCLES   = 8;
	localparam int FILL_PIECES    = 12;
	localparam logic [31:0] LFSR_SEED = 32'd75722;

	logic      Clk;
	logic      Reset;
	logic      Start;
	logic      Ack;
	logic      Left;
	logic      Right;
	logic      Down;
	logic      Rotate;
	logic      q_I;
	logic      q_Gen;
	logic      q_Rot;
	logic      q_Col;
	logic      q_Lose;
	board_t    blocks;
	score_t    score;
	cell_idx_t location;
	orient_t   orientation;

	int          cycle_cnt;
	int          fails;
	logic [31:0] lfsr;

	tetris_top dut_i (
		.Clk         (Clk),
		.Reset       (Reset),
		.Start       (Start),
		.Ack         (Ack),
		.Left        (Left),
		.Right       (Right),
		.Down        (Down),
		.Rotate      (Rotate),
		.q_I         (q_I),
		.q_Gen       (q_Gen),
		.q_Rot       (q_Rot),
		.q_Col       (q_Col),
		.q_Lose      (q_Lose),
		.blocks      (blocks),
		.score       (score),
		.location    (location),
		.orientation (orientation)
	);

	always #5 Clk = !Clk;

	always @(posedge Clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Assertion failures: %0d, timeouts: 1", dut_i.asserts_i.fail_cnt);
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// 32-bit Galois LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic rand_bit(output logic b);
		b = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	// 1 with chance 1/2^n
	task automatic rand_and(input int n, output logic b);
		logic bit_v;
		b = 1'b1;
		for (int i = 0; i < n; i++)
		begin
			rand_bit(bit_v);
			b = b & bit_v;
		end
	endtask

	task automatic set_inputs(input logic l, input logic r, input logic d,
		input logic rot, input logic st, input logic ak);
		@(posedge Clk);
		Left   <= l;
		Right  <= r;
		Down   <= d;
		Rotate <= rot;
		Start  <= st;
		Ack    <= ak;
	endtask

	task automatic wait_play_or_lose();
		@(negedge Clk);
		while (!q_Rot && !q_Lose)
			@(negedge Clk);
	endtask

	// One Down, optional rotate, sideways moves, then Down until the lock
	task automatic drop_piece(input int shift, input logic turn);
		int steps;
		steps = (shift < 0) ? -shift : shift;
		if (q_Rot)
		begin
			set_inputs(0, 0, 1, 0, 0, 0);
			set_inputs(0, 0, 0, turn, 0, 0);
			for (int i = 0; i < steps; i++)
			begin
				set_inputs(shift < 0, shift > 0, 0, 0, 0, 0);
				set_inputs(0, 0, 0, 0, 0, 0);
			end
			set_inputs(0, 0, 1, 0, 0, 0);
			@(negedge Clk);
			while (q_Rot)
				@(negedge Clk);
			set_inputs(0, 0, 0, 0, 0, 0);
			@(negedge Clk);
		end
	endtask

	// Flat bars and square pairs tiled into the left and right halves
	task automatic fill_rows(input int pieces);
		int   height [2];
		int   pend_half;
		int   half;
		logic is_bar;
		height    = '{0, 0};
		pend_half = -1;
		for (int p = 0; p < pieces; p++)
		begin
			wait_play_or_lose();
			// Only the flat bar covers column 0 of the top row at spawn
			is_bar = blocks[(BOARD_ROWS-1)*BOARD_COLS];
			if (is_bar)
			begin
				if (pend_half >= 0)
					half = 1 - pend_half;
				else
					half = (height[1] < height[0]) ? 1 : 0;
				height[half] += 1;
				drop_piece((half == 0) ? 0 : 4, 1'b0);
			end
			else if (pend_half >= 0)
			begin
				// Second square takes the right pair of the half
				drop_piece((pend_half == 0) ? 1 : 5, 1'b0);
				height[pend_half] += 2;
				pend_half = -1;
			end
			else
			begin
				pend_half = (height[1] < height[0]) ? 1 : 0;
				drop_piece((pend_half == 0) ? -1 : 3, 1'b0);
			end
		end
	endtask

	task automatic random_step();
		logic l;
		logic r;
		logic d_n;
		logic rot;
		logic st;
		logic ak;
		rand_and(3, l);
		rand_and(3, r);
		rand_and(2, d_n);
		rand_and(2, rot);
		rand_and(1, st);
		rand_and(2, ak);
		set_inputs(l, r, !d_n, rot, st, ak);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		Clk       = 1'b0;
		Reset     = 1'b1;
		Start     = 1'b0;
		Ack       = 1'b0;
		Left      = 1'b0;
		Right     = 1'b0;
		Down      = 1'b0;
		Rotate    = 1'b0;
		cycle_cnt = 0;
		lfsr      = LFSR_SEED;
		repeat (RESET_CYCLES) @(posedge Clk);
		Reset <= 1'b0;

		// Rows filled across both halves so that they clear
		set_inputs(0, 0, 0, 0, 1, 0);
		set_inputs(0, 0, 0, 0, 0, 0);
		fill_rows(FILL_PIECES);

		// Stack at the spawn columns until the spawn no longer fits
		while (!q_Lose)
		begin
			wait_play_or_lose();
			drop_piece(0, 1'b1);
		end
		set_inputs(0, 0, 0, 0, 0, 1);
		set_inputs(0, 0, 0, 0, 1, 0);
		set_inputs(0, 0, 0, 0, 0, 0);

		repeat (RANDOM_CYCLES) random_step();
		set_inputs(0, 0, 0, 0, 0, 0);
		// Last implications resolve one edge later
		repeat (2) @(negedge Clk);

		fails = dut_i.asserts_i.fail_cnt;
		$display("Assertion failures: %0d, timeouts: 0", fails);
		if (fails == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* design/board_pkg.sv */
package board_pkg;

	////////////////////////////////////////////////////////////
	// Board geometry
	////////////////////////////////////////////////////////////

	localparam int BOARD_COLS  = 8;
	localparam int BOARD_ROWS  = 20;
	localparam int BOARD_CELLS = BOARD_COLS * BOARD_ROWS;
	localparam int ROW_W       = $clog2(BOARD_ROWS);

	// Cell index is row * 8 + column, row 0 at the bottom
	typedef logic [7:0] cell_idx_t;
	typedef logic [BOARD_CELLS-1:0] board_t;
	typedef logic [ROW_W-1:0] row_idx_t;

	// Wraps at 255
	typedef logic [7:0] score_t;

	////////////////////////////////////////////////////////////
	// Game timing
	////////////////////////////////////////////////////////////

	// PLAY cycles without a Down step before gravity acts
	localparam int DROP_TICKS = 64;
	localparam int DROP_CNT_W = $clog2(DROP_TICKS);

	typedef logic [DROP_CNT_W-1:0] drop_cnt_t;

	////////////////////////////////////////////////////////////
	// Game states, one-hot
	////////////////////////////////////////////////////////////

	// Bit order matches q_Lose, q_Col, q_Rot, q_Gen, q_I
	typedef enum logic [4:0] {
		INITIAL   = 5'b00001,
		GENERATE  = 5'b00010,
		PLAY      = 5'b00100,
		COLLISION = 5'b01000,
		LOSE      = 5'b10000
	} game_state_t;

endpackage

/* design/board_store.sv */
`timescale 1ns/1ps

module board_store
	import board_pkg::*;
(
	input  logic        Clk,
	input  logic        Reset,
	input  game_state_t state,
	input  logic        lock,
	input  board_t      piece_cells,
	output board_t      stack,
	output board_t      blocks,
	output score_t      score,
	output logic        clearing
);

	logic [BOARD_ROWS-1:0] row_full;
	row_idx_t              low_row;
	board_t                collapsed;
	logic                  piece_live;

	// Extra empty row above the top for the shift
	logic [BOARD_CELLS+BOARD_COLS-1:0] stack_ext;

	////////////////////////////////////////////////////////////
	// Full-row detection
	////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int r = 0; r < BOARD_ROWS; r++)
			row_full[r] = &stack[r*BOARD_COLS +: BOARD_COLS];
	end

	assign clearing = |row_full;

	// Lowest full row wins
	always_comb
	begin
		low_row = '0;
		for (int r = BOARD_ROWS - 1; r >= 0; r--)
			if (row_full[r])
				low_row = row_idx_t'(r);
	end

	assign stack_ext = {{BOARD_COLS{1'b0}}, stack};

	// Rows from low_row up drop by one
	always_comb
	begin
		collapsed = stack;
		for (int r = 0; r < BOARD_ROWS; r++)
			if (r >= int'(low_row))
				collapsed[r*BOARD_COLS +: BOARD_COLS] = stack_ext[(r+1)*BOARD_COLS +: BOARD_COLS];
	end

	////////////////////////////////////////////////////////////
	// Settled stack and score
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			stack <= '0;
			score <= '0;
		end
		else if (state == INITIAL)
		begin
			stack <= '0;
			score <= '0;
		end
		else if (lock)
			stack <= stack | piece_cells;
		else if (clearing)
		begin
			stack <= collapsed;
			score <= score + 1'b1;
		end
	end

	// Piece shown from spawn until it is locked
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			piece_live <= 1'b0;
		else if (state == GENERATE)
			piece_live <= 1'b1;
		else if (lock || state == INITIAL)
			piece_live <= 1'b0;
	end

	assign blocks = (piece_live && (state == PLAY || state == COLLISION)) ?
		(stack | piece_cells) : stack;

endmodule

/* design/game_fsm.sv */
`timescale 1ns/1ps

module game_fsm
	import board_pkg::*;
	import piece_pkg::*;
(
	input  logic        Clk,
	input  logic        Reset,
	input  logic        Start,
	input  logic        Ack,
	input  logic        spawn_fits,
	input  logic        can_fall,
	input  logic        moved_down,
	input  logic        clearing,
	output game_state_t state,
	output logic        spawn,
	output logic        step_down,
	output logic        lock,
	output piece_kind_t next_kind
);

	drop_cnt_t drop_cnt;
	logic      gravity_due;
	logic      locked;
	logic      toggle;

	assign gravity_due = (drop_cnt == drop_cnt_t'(DROP_TICKS - 1));

	assign spawn     = (state == GENERATE);
	assign step_down = (state == COLLISION) && !locked && can_fall;
	assign lock      = (state == COLLISION) && !locked && !can_fall;

	// Free-running piece chooser
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			toggle <= 1'b0;
		else
			toggle <= !toggle;
	end

	////////////////////////////////////////////////////////////
	// State, gravity timer, lock tracking
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state     <= INITIAL;
			drop_cnt  <= '0;
			locked    <= 1'b0;
			next_kind <= SQUARE;
		end
		else
		begin
			case (state)
				INITIAL:
					if (Start)
						state <= GENERATE;
				GENERATE:
				begin
					// Pick the piece after this one
					next_kind <= piece_kind_t'(toggle);
					locked    <= 1'b0;
					drop_cnt  <= '0;
					state     <= spawn_fits ? PLAY : LOSE;
				end
				PLAY:
				begin
					if (moved_down)
						drop_cnt <= '0;
					else if (gravity_due)
					begin
						drop_cnt <= '0;
						state    <= COLLISION;
					end
					else
						drop_cnt <= drop_cnt + 1'b1;
				end
				COLLISION:
				begin
					if (step_down)
					begin
						drop_cnt <= '0;
						state    <= PLAY;
					end
					else if (lock)
						locked <= 1'b1;
					else if (!clearing)
					begin
						locked <= 1'b0;
						state  <= GENERATE;
					end
				end
				LOSE:
					if (Ack)
						state <= INITIAL;
				default:
					state <= INITIAL;
			endcase
		end
	end

endmodule

/* design/piece_mover.sv */
`timescale 1ns/1ps

module piece_mover
	import board_pkg::*;
	import piece_pkg::*;
(
	input  logic        Clk,
	input  logic        Reset,
	input  logic        Left,
	input  logic        Right,
	input  logic        Down,
	input  logic        Rotate,
	input  game_state_t state,
	input  logic        spawn,
	input  logic        step_down,
	input  piece_kind_t next_kind,
	input  board_t      stack,
	output cell_idx_t   location,
	output orient_t     orientation,
	output board_t      piece_cells,
	output logic        spawn_fits,
	output logic        can_fall,
	output logic        moved_down
);

	piece_kind_t kind;
	orient_t     rot_orient;

	placement_t cur_pl;
	placement_t left_pl;
	placement_t right_pl;
	placement_t down_pl;
	placement_t rot_pl;
	placement_t spawn_pl;

	logic left_ok;
	logic right_ok;
	logic down_ok;
	logic rot_ok;

	////////////////////////////////////////////////////////////
	// Candidate placements
	////////////////////////////////////////////////////////////

	// Flat and upright swap, anchor stays put
	assign rot_orient = orientation ^ ORIENT_UPRIGHT;

	assign cur_pl   = piece_place(kind, orientation, location, 0, 0);
	assign left_pl  = piece_place(kind, orientation, location, 0, -1);
	assign right_pl = piece_place(kind, orientation, location, 0, 1);
	assign down_pl  = piece_place(kind, orientation, location, -1, 0);
	assign rot_pl   = piece_place(kind, rot_orient, location, 0, 0);
	assign spawn_pl = piece_place(next_kind, ORIENT_FLAT, SPAWN_ANCHOR, 0, 0);

	assign can_fall   = placement_fits(down_pl, stack);
	assign spawn_fits = placement_fits(spawn_pl, stack);

	// Priority Left, Right, Down, Rotate
	assign left_ok  = Left && placement_fits(left_pl, stack);
	assign right_ok = Right && placement_fits(right_pl, stack);
	assign down_ok  = Down && can_fall;
	assign rot_ok   = Rotate && (kind == BAR) && placement_fits(rot_pl, stack);

	assign moved_down = (state == PLAY) && !left_ok && !right_ok && down_ok;

	assign piece_cells = placement_mask(cur_pl);

	////////////////////////////////////////////////////////////
	// Falling piece register
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			kind        <= SQUARE;
			location    <= '0;
			orientation <= ORIENT_FLAT;
		end
		else if (state == INITIAL)
		begin
			location    <= '0;
			orientation <= ORIENT_FLAT;
		end
		else if (spawn)
		begin
			kind        <= next_kind;
			location    <= SPAWN_ANCHOR;
			orientation <= ORIENT_FLAT;
		end
		else if (step_down)
			location <= location - cell_idx_t'(BOARD_COLS);
		else if (state == PLAY)
		begin
			if (left_ok)
				location <= location - 1'b1;
			else if (right_ok)
				location <= location + 1'b1;
			else if (down_ok)
				location <= location - cell_idx_t'(BOARD_COLS);
			else if (rot_ok)
				orientation <= rot_orient;
		end
	end

endmodule

/* design/piece_pkg.sv */
package piece_pkg;

	import board_pkg::*;

	typedef enum logic {
		SQUARE = 1'b0,
		BAR    = 1'b1
	} piece_kind_t;

	// Only the bar ever goes upright
	typedef logic [1:0] orient_t;

	localparam orient_t ORIENT_FLAT    = 2'd0;
	localparam orient_t ORIENT_UPRIGHT = 2'd1;

	// Row 19, column 2
	localparam cell_idx_t SPAWN_ANCHOR = 8'd154;

	localparam int PIECE_CELLS = 4;

	////////////////////////////////////////////////////////////
	// Offsets from the anchor: square, flat bar, upright bar
	////////////////////////////////////////////////////////////

	localparam int ROW_OFS [3][PIECE_CELLS] = '{'{0, 0, -1, -1}, '{0, 0, 0, 0}, '{1, 0, -1, -2}};
	localparam int COL_OFS [3][PIECE_CELLS] = '{'{0, -1, 0, -1}, '{-2, -1, 0, 1}, '{0, 0, 0, 0}};

	typedef struct packed {
		logic off_board;
		cell_idx_t [PIECE_CELLS-1:0] cells;
	} placement_t;

	function automatic int shape_sel(piece_kind_t kind, orient_t orient);
		if (kind == SQUARE)
			return 0;
		return (orient == ORIENT_UPRIGHT) ? 2 : 1;
	endfunction

	// Four cells of a placement, anchor shifted by drow rows and dcol columns
	function automatic placement_t piece_place(piece_kind_t kind, orient_t orient,
		cell_idx_t anchor, int drow, int dcol);
		placement_t p;
		int shape;
		int row;
		int col;
		shape = shape_sel(kind, orient);
		p.off_board = 1'b0;
		for (int i = 0; i < PIECE_CELLS; i++)
		begin
			row = int'(anchor) / BOARD_COLS + drow + ROW_OFS[shape][i];
			col = int'(anchor) % BOARD_COLS + dcol + COL_OFS[shape][i];
			if (row < 0 || row >= BOARD_ROWS || col < 0 || col >= BOARD_COLS)
				p.off_board = 1'b1;
			p.cells[i] = cell_idx_t'(row * BOARD_COLS + col);
		end
		return p;
	endfunction

	function automatic board_t placement_mask(placement_t p);
		board_t m;
		m = '0;
		if (!p.off_board)
			for (int i = 0; i < PIECE_CELLS; i++)
				m[p.cells[i]] = 1'b1;
		return m;
	endfunction

	function automatic logic placement_fits(placement_t p, board_t stack);
		return !p.off_board && ((placement_mask(p) & stack) == '0);
	endfunction

endpackage

/* design/tetris_top.sv */
`timescale 1ns/1ps

module tetris_top
	import board_pkg::*;
	import piece_pkg::*;
(
	input  logic      Clk,
	input  logic      Reset,
	input  logic      Start,
	input  logic      Ack,
	input  logic      Left,
	input  logic      Right,
	input  logic      Down,
	input  logic      Rotate,
	output logic      q_I,
	output logic      q_Gen,
	output logic      q_Rot,
	output logic      q_Col,
	output logic      q_Lose,
	output board_t    blocks,
	output score_t    score,
	output cell_idx_t location,
	output orient_t   orientation
);

	game_state_t state;
	piece_kind_t next_kind;
	board_t      piece_cells;
	board_t      stack;

	logic spawn;
	logic step_down;
	logic lock;
	logic spawn_fits;
	logic can_fall;
	logic moved_down;
	logic clearing;

	// State flags straight off the one-hot register
	assign {q_Lose, q_Col, q_Rot, q_Gen, q_I} = state;

	game_fsm fsm_i (
		.Clk        (Clk),
		.Reset      (Reset),
		.Start      (Start),
		.Ack        (Ack),
		.spawn_fits (spawn_fits),
		.can_fall   (can_fall),
		.moved_down (moved_down),
		.clearing   (clearing),
		.state      (state),
		.spawn      (spawn),
		.step_down  (step_down),
		.lock       (lock),
		.next_kind  (next_kind)
	);

	piece_mover mover_i (
		.Clk         (Clk),
		.Reset       (Reset),
		.Left        (Left),
		.Right       (Right),
		.Down        (Down),
		.Rotate      (Rotate),
		.state       (state),
		.spawn       (spawn),
		.step_down   (step_down),
		.next_kind   (next_kind),
		.stack       (stack),
		.location    (location),
		.orientation (orientation),
		.piece_cells (piece_cells),
		.spawn_fits  (spawn_fits),
		.can_fall    (can_fall),
		.moved_down  (moved_down)
	);

	board_store store_i (
		.Clk         (Clk),
		.Reset       (Reset),
		.state       (state),
		.lock        (lock),
		.piece_cells (piece_cells),
		.stack       (stack),
		.blocks      (blocks),
		.score       (score),
		.clearing    (clearing)
	);

endmodule

/* filelist.f */
design/board_pkg.sv
design/piece_pkg.sv
design/game_fsm.sv
design/piece_mover.sv
design/board_store.sv
design/tetris_top.sv
bench/tetris_asserts.sv
bench/tetris_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the tetris testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tetris_tb -f filelist.f -o tetris_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tetris_sim +verilator+error+limit+100000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q -F '*** PASSED ***'; then
	exit 0
fi
echo "Simulation did not pass"
exit 1
